//--- list.f
verilog/arp_frame_pkg.sv
verilog/arp_decode_pkg.sv
verilog/arp_field_capture.sv
verilog/arp_target_match.sv
verilog/arp_result_merge.sv
verilog/arp_decoder.sv
tb/arp_decoder_props.sv
tb/tb_arp_decoder.sv

//--- tb/arp_decoder_props.sv
`timescale 1ns/100ps

module arp_decoder_props (
	input logic                      CLK,
	input logic                      RST,
	input logic                      byte_take,
	input arp_frame_pkg::byte_idx_t  byte_idx,
	input logic                      arp_done,
	input arp_decode_pkg::arp_kind_t arp_type
);
	import arp_frame_pkg::*;
	import arp_decode_pkg::*;

	localparam int DONE_DELAY = 30;  // Accepting edge to the edge that sees arp_done

	logic accepted;

	// Byte 0 is only taken when the capture sits in IDLE
	assign accepted = byte_take && (byte_idx == '0);

	done_single: assert property (@(posedge CLK) disable iff (RST)
		arp_done |=> !arp_done)
		else $error("arp_done high on two cycles in a row");

	done_after_accept: assert property (@(posedge CLK) disable iff (RST)
		accepted |-> ##DONE_DELAY arp_done)
		else $error("arp_done missing after an accepted frame");

	done_has_accept: assert property (@(posedge CLK) disable iff (RST)
		arp_done |-> $past(accepted, DONE_DELAY))
		else $error("arp_done without a frame accepted at the expected edge");

	type_legal: assert property (@(posedge CLK) disable iff (RST)
		arp_type != 2'd3)
		else $error("arp_type holds the unused code 3");

endmodule

bind arp_decoder arp_decoder_props i_props (
	.CLK       (CLK),
	.RST       (RST),
	.byte_take (byte_take),
	.byte_idx  (byte_idx),
	.arp_done  (arp_done),
	.arp_type  (arp_type)
);

//--- tb/arp_golden.txt
# Each record is a tag, the 28 body bytes in stream order, then the expected kind
# (0 unsupported, 1 ARP, 2 RARP) and the expected header in hex, or hold
arp_req_a
  00 01 08 00 06 04 00 01 02 11 22 33 44 55 c0 a8 00 0a 00 00 00 00 00 00 c0 a8 00 01
  1 c0a80001000000000000c0a8000a0211223344550001040608000001
# Last destination byte differs
foreign_ip_a
  00 01 08 00 06 04 00 01 02 11 22 33 44 55 c0 a8 00 0a 00 00 00 00 00 00 c0 a8 00 02
  0 hold
rarp_req_a
  00 01 08 00 06 04 00 03 0a 1b 2c 3d 4e 5f 00 00 00 00 aa bb cc dd ee ff c0 a8 00 01
  2 c0a80001aabbccddeeff000000000a1b2c3d4e5f0003040608000001
# Opcode high byte set
oper_0101_local
  00 01 08 00 06 04 01 01 0a 1b 2c 3d 4e 5f 00 00 00 00 aa bb cc dd ee ff c0 a8 00 01
  0 00000000000000000000000000000000000000000000000000000000
arp_req_b
  00 06 08 00 06 04 00 01 00 1a 2b 3c 4d 5e 0a 00 00 05 ff ff ff ff ff ff c0 a8 00 01
  1 c0a80001ffffffffffff0a000005001a2b3c4d5e0001040608000006
reply_local
  00 01 08 00 06 04 00 02 02 11 22 33 44 55 c0 a8 00 01 02 66 77 88 99 aa c0 a8 00 01
  0 00000000000000000000000000000000000000000000000000000000
# First destination byte differs
foreign_ip_b
  00 01 08 00 06 04 00 01 02 11 22 33 44 55 c0 a8 00 0a 00 00 00 00 00 00 0a a8 00 01
  0 hold
rarp_req_b
  00 01 08 00 06 04 00 03 12 34 56 78 9a bc 00 00 00 00 12 34 56 78 9a bc c0 a8 00 01
  2 c0a80001123456789abc00000000123456789abc0003040608000001
# Third destination byte differs
foreign_ip_c
  00 01 08 00 06 04 00 03 12 34 56 78 9a bc 00 00 00 00 12 34 56 78 9a bc c0 a8 01 01
  0 hold
arp_req_c
  00 01 08 00 06 04 00 01 a5 5a c3 3c 96 69 c0 a8 00 64 00 00 00 00 00 00 c0 a8 00 01
  1 c0a80001000000000000c0a80064a55ac33c96690001040608000001

//--- tb/tb_arp_decoder.sv
`timescale 1ns/100ps

module tb_arp_decoder;
	import arp_frame_pkg::*;
	import arp_decode_pkg::*;

	localparam ip_addr_t LOCAL_IP     = 32'hC0A80001;
	localparam int       DONE_LATENCY = 30;  // Strobe drive to done sample, in cycles
	localparam int       WAIT_LIMIT   = 40;
	localparam int       MAX_GAP      = 5;
	localparam int       PARTIAL      = 12;  // Bytes sent before the mid-frame reset

	logic        CLK = 1'b0;
	logic        RST;
	byte_t       in_data;
	logic        arp_en;
	arp_header_t arp_header;
	arp_kind_t   arp_type;
	logic        arp_done;

	// Golden records, one entry per test
	string       tag_q[$];
	arp_header_t stream_q[$];  // Byte 0 in the top 8 bits
	arp_kind_t   kind_q[$];
	arp_header_t header_q[$];
	bit          hold_q[$];

	logic [31:0] rnd_state;
	arp_header_t last_header;
	int          cyc = 0;
	int          done_count = 0;
	int          frames_done = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          mismatches = 0;

	arp_decoder #(
		.LOCAL_IP (LOCAL_IP)
	) i_dut (
		.CLK        (CLK),
		.RST        (RST),
		.in_data    (in_data),
		.arp_en     (arp_en),
		.arp_header (arp_header),
		.arp_type   (arp_type),
		.arp_done   (arp_done)
	);

	always #5 CLK = ~CLK;

	always @(posedge CLK) begin
		cyc <= cyc + 1;
		if (!RST && arp_done)
			done_count <= done_count + 1;  // One per decoded frame
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_value(input logic [223:0] got, input logic [223:0] exp,
		input string what);
		if (got !== exp) begin
			$display("mismatch @%0t: %s got %0h expected %0h", $time, what, got, exp);
			mismatches++;
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$finish;
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (mismatches != errs_before) begin
			tests_failed++;
			$display("test %s failed", name);
		end else begin
			$display("test %s ok", name);
		end
	endtask

	task automatic load_golden();
		int          fd;
		int          n;
		int          k;
		int          kind;
		string       tag;
		string       rest;
		string       hdr_text;
		byte_t       b;
		arp_header_t stream;
		arp_header_t header;
		fd = $fopen("tb/arp_golden.txt", "r");
		if (fd == 0)
			abort_run("cannot open the golden file tb/arp_golden.txt");
		while ($fscanf(fd, "%s", tag) == 1) begin
			if (tag.substr(0, 0) == "#") begin
				n = $fgets(rest, fd);  // Comment line
			end else begin
				stream = '0;
				for (k = 0; k < FRAME_BYTES; k++) begin
					n = $fscanf(fd, "%h", b);
					if (n != 1)
						abort_run({"golden record ", tag, " has too few bytes"});
					stream[223 - 8 * k -: 8] = b;
				end
				n = $fscanf(fd, "%d %s", kind, hdr_text);
				if (n != 2)
					abort_run({"golden record ", tag, " lacks kind or header"});
				header = '0;
				if (hdr_text != "hold")
					n = $sscanf(hdr_text, "%h", header);
				tag_q.push_back(tag);
				stream_q.push_back(stream);
				kind_q.push_back(arp_kind_t'(kind));
				header_q.push_back(header);
				hold_q.push_back(hdr_text == "hold");
			end
		end
		$fclose(fd);
		if (tag_q.size() == 0)
			abort_run("the golden file holds no test records");
	endtask

	// Strobe low, random bytes on the bus
	task automatic idle_cycles(input int count);
		int k;
		for (k = 0; k < count; k++) begin
			@(negedge CLK);
			arp_en    = 1'b0;
			rnd_state = lcg_next(rnd_state);
			in_data   = rnd_state[23:16];
		end
	endtask

	// With no_wait the strobe goes out on the current falling edge
	task automatic send_frame(input arp_header_t stream, input bit no_wait,
		output int latency, output bit timed_out);
		int start;
		int waited;
		int k;
		if (!no_wait)
			@(negedge CLK);
		arp_en  = 1'b1;
		in_data = stream[223 -: 8];
		start   = cyc;
		for (k = 1; k < FRAME_BYTES; k++) begin
			@(negedge CLK);
			arp_en  = 1'b0;
			in_data = stream[223 - 8 * k -: 8];
		end
		waited = 0;
		do begin
			@(negedge CLK);
			in_data = '0;
			waited++;
		end while (!arp_done && waited < WAIT_LIMIT);
		timed_out = !arp_done;
		latency   = cyc - start;
	endtask

	task automatic run_test(input int idx, input bit no_gap);
		int          gap;
		int          latency;
		int          errs_before;
		bit          timed_out;
		string       name;
		arp_header_t exp_header;
		errs_before = mismatches;
		name        = tag_q[idx];
		if (!no_gap) begin
			rnd_state = lcg_next(rnd_state);
			gap       = rnd_state[31:16] % (MAX_GAP + 1);
			idle_cycles(gap);
		end
		send_frame(stream_q[idx], no_gap, latency, timed_out);
		if (timed_out)
			abort_run({"timeout waiting for arp_done in test ", name});
		frames_done++;
		exp_header = hold_q[idx] ? last_header : header_q[idx];  // Foreign IP keeps the old one
		check_value(arp_type, kind_q[idx], {name, " arp_type"});
		check_value(arp_header, exp_header, {name, " arp_header"});
		check_value(latency, DONE_LATENCY, {name, " done latency"});
		last_header = exp_header;
		report_test(name, errs_before);
	endtask

	task automatic reset_mid_frame();
		int          errs_before;
		int          k;
		arp_header_t stream;
		errs_before = mismatches;
		stream      = stream_q[0];
		@(negedge CLK);
		arp_en  = 1'b1;
		in_data = stream[223 -: 8];
		for (k = 1; k < PARTIAL; k++) begin
			@(negedge CLK);
			arp_en  = 1'b0;
			in_data = stream[223 - 8 * k -: 8];
		end
		@(negedge CLK);
		RST     = 1'b1;
		in_data = '0;
		@(negedge CLK);
		check_value(arp_done, 1'b0, "reset arp_done");
		check_value(arp_type, KIND_UNSUPPORTED, "reset arp_type");
		check_value(arp_header, '0, "reset arp_header");
		repeat (4) @(negedge CLK);
		RST         = 1'b0;
		last_header = '0;
		report_test("reset_mid_frame", errs_before);
	endtask

	initial begin
		int i;
		RST         = 1'b1;
		arp_en      = 1'b0;
		in_data     = '0;
		rnd_state   = 32'h14115cdc;
		last_header = '0;
		load_golden();
		repeat (5) @(negedge CLK);
		RST = 1'b0;

		// First pass with random idle gaps
		for (i = 0; i < tag_q.size(); i++)
			run_test(i, 1'b0);

		reset_mid_frame();

		for (i = 0; i < tag_q.size(); i++)
			run_test(i, 1'b1);  // Back to back, strobe in each done cycle

		idle_cycles(3);
		check_value(done_count, frames_done, "arp_done pulse count");
		$display("tests run %0d, tests failed %0d, mismatches %0d",
			tests_run, tests_failed, mismatches);
		if (mismatches == 0 && tests_failed == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- verilog/arp_decode_pkg.sv
package arp_decode_pkg;

	// Opcodes the decoder answers to
	localparam arp_frame_pkg::word16_t OPER_ARP_REQUEST  = 16'h0001;
	localparam arp_frame_pkg::word16_t OPER_RARP_REQUEST = 16'h0003;

	// Message kind reported on arp_type
	typedef logic [1:0] arp_kind_t;

	localparam arp_kind_t KIND_UNSUPPORTED = 2'd0;
	localparam arp_kind_t KIND_ARP         = 2'd1;
	localparam arp_kind_t KIND_RARP        = 2'd2;

	// Capture FSM
	typedef enum logic [1:0] {
		IDLE,     // Waiting for arp_en
		COLLECT,  // Bytes 1..27
		DECIDE,   // Flags and header complete
		REPORT    // Result stage loads, back to IDLE next
	} cap_state_t;

endpackage

//--- verilog/arp_decoder.sv
`timescale 1ns/100ps

module arp_decoder #(
	parameter arp_frame_pkg::ip_addr_t LOCAL_IP = 32'hC0A8_0001
) (
	input  logic                       CLK,
	input  logic                       RST,
	input  arp_frame_pkg::byte_t       in_data,
	input  logic                       arp_en,
	output arp_frame_pkg::arp_header_t arp_header,
	output arp_decode_pkg::arp_kind_t  arp_type,
	output logic                       arp_done
);
	import arp_frame_pkg::*;
	import arp_decode_pkg::*;

	// Capture to match
	byte_idx_t   byte_idx;
	logic        byte_take;

	// Capture and match to result stage
	logic        decide;
	arp_header_t frame_header;
	logic        ip_hit;
	arp_kind_t   oper_kind;

	arp_field_capture i_capture (
		.CLK          (CLK),
		.RST          (RST),
		.in_data      (in_data),
		.arp_en       (arp_en),
		.byte_idx     (byte_idx),
		.byte_take    (byte_take),
		.decide       (decide),
		.frame_header (frame_header)
	);

	// Watches the same bytes as the capture
	arp_target_match #(
		.LOCAL_IP (LOCAL_IP)
	) i_match (
		.CLK       (CLK),
		.RST       (RST),
		.in_data   (in_data),
		.byte_idx  (byte_idx),
		.byte_take (byte_take),
		.ip_hit    (ip_hit),
		.oper_kind (oper_kind)
	);

	arp_result_merge i_merge (
		.CLK          (CLK),
		.RST          (RST),
		.decide       (decide),
		.ip_hit       (ip_hit),
		.oper_kind    (oper_kind),
		.frame_header (frame_header),
		.arp_header   (arp_header),
		.arp_type     (arp_type),
		.arp_done     (arp_done)
	);

endmodule

//--- verilog/arp_field_capture.sv
`timescale 1ns/100ps

module arp_field_capture (
	input  logic                       CLK,
	input  logic                       RST,
	input  arp_frame_pkg::byte_t       in_data,
	input  logic                       arp_en,
	output arp_frame_pkg::byte_idx_t   byte_idx,
	output logic                       byte_take,
	output logic                       decide,
	output arp_frame_pkg::arp_header_t frame_header
);
	import arp_frame_pkg::*;
	import arp_decode_pkg::*;

	cap_state_t state;

	// Bit position of the LSB of stream byte idx inside the header.
	// Fields are big endian, fields themselves are stacked from the bottom up.
	function automatic int unsigned hdr_lsb(input byte_idx_t idx);
		int unsigned i;
		i = idx;
		if (i >= OFS_DST_IP)
			return POS_DST_IP + $bits(ip_addr_t) - 8 * (i - OFS_DST_IP + 1);
		if (i >= OFS_DST_MAC)
			return POS_DST_MAC + $bits(mac_addr_t) - 8 * (i - OFS_DST_MAC + 1);
		if (i >= OFS_SRC_IP)
			return POS_SRC_IP + $bits(ip_addr_t) - 8 * (i - OFS_SRC_IP + 1);
		if (i >= OFS_SRC_MAC)
			return POS_SRC_MAC + $bits(mac_addr_t) - 8 * (i - OFS_SRC_MAC + 1);
		if (i >= OFS_OPER)
			return POS_OPER + $bits(word16_t) - 8 * (i - OFS_OPER + 1);
		if (i >= OFS_PLEN)
			return POS_PLEN + $bits(byte_t) - 8 * (i - OFS_PLEN + 1);
		if (i >= OFS_HLEN)
			return POS_HLEN + $bits(byte_t) - 8 * (i - OFS_HLEN + 1);
		if (i >= OFS_PTYPE)
			return POS_PTYPE + $bits(word16_t) - 8 * (i - OFS_PTYPE + 1);
		return POS_HTYPE + $bits(word16_t) - 8 * (i - OFS_HTYPE + 1);
	endfunction

	// Byte 0 is taken in IDLE together with the strobe
	assign byte_take = (state == COLLECT) || (state == IDLE && arp_en);
	assign decide    = (state == DECIDE);

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			state    <= IDLE;
			byte_idx <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (arp_en) begin
						state    <= COLLECT;
						byte_idx <= byte_idx + 1'b1;
					end
				end
				COLLECT: begin
					byte_idx <= byte_idx + 1'b1;
					if (byte_idx == byte_idx_t'(FRAME_BYTES - 1))
						state <= DECIDE;  // Last body byte this cycle
				end
				DECIDE: begin
					state    <= REPORT;
					byte_idx <= byte_idx + 1'b1;
				end
				REPORT: begin
					state    <= IDLE;     // Ready for a strobe in the done cycle
					byte_idx <= '0;
				end
			endcase
		end
	end

	// Header register, each byte lands in its own field
	always_ff @(posedge CLK) begin
		if (byte_take)
			frame_header[hdr_lsb(byte_idx) +: $bits(byte_t)] <= in_data;
	end

endmodule

//--- verilog/arp_frame_pkg.sv
package arp_frame_pkg;

	// Field types of the ARP body
	typedef logic [7:0]   byte_t;
	typedef logic [15:0]  word16_t;      // Hardware type, protocol type, opcode
	typedef logic [47:0]  mac_addr_t;
	typedef logic [31:0]  ip_addr_t;
	typedef logic [223:0] arp_header_t;  // Whole body, packed field order
	typedef logic [4:0]   byte_idx_t;    // 0..27 bytes, 28 decide, 29 report

	localparam int unsigned FRAME_BYTES = 28;

	// Byte offsets in the stream
	localparam int unsigned OFS_HTYPE   = 0;
	localparam int unsigned OFS_PTYPE   = 2;
	localparam int unsigned OFS_HLEN    = 4;
	localparam int unsigned OFS_PLEN    = 5;
	localparam int unsigned OFS_OPER    = 6;
	localparam int unsigned OFS_SRC_MAC = 8;
	localparam int unsigned OFS_SRC_IP  = 14;
	localparam int unsigned OFS_DST_MAC = 18;
	localparam int unsigned OFS_DST_IP  = 24;

	// Field LSB positions inside arp_header_t
	// Hardware type sits at the bottom, destination IP at the top
	localparam int unsigned POS_HTYPE   = 0;
	localparam int unsigned POS_PTYPE   = POS_HTYPE + $bits(word16_t);
	localparam int unsigned POS_HLEN    = POS_PTYPE + $bits(word16_t);
	localparam int unsigned POS_PLEN    = POS_HLEN + $bits(byte_t);
	localparam int unsigned POS_OPER    = POS_PLEN + $bits(byte_t);
	localparam int unsigned POS_SRC_MAC = POS_OPER + $bits(word16_t);
	localparam int unsigned POS_SRC_IP  = POS_SRC_MAC + $bits(mac_addr_t);
	localparam int unsigned POS_DST_MAC = POS_SRC_IP + $bits(ip_addr_t);
	localparam int unsigned POS_DST_IP  = POS_DST_MAC + $bits(mac_addr_t);

endpackage

//--- verilog/arp_result_merge.sv
`timescale 1ns/100ps

module arp_result_merge (
	input  logic                       CLK,
	input  logic                       RST,
	input  logic                       decide,
	input  logic                       ip_hit,
	input  arp_decode_pkg::arp_kind_t  oper_kind,
	input  arp_frame_pkg::arp_header_t frame_header,
	output arp_frame_pkg::arp_header_t arp_header,
	output arp_decode_pkg::arp_kind_t  arp_type,
	output logic                       arp_done
);
	import arp_frame_pkg::*;
	import arp_decode_pkg::*;

	arp_kind_t   next_type;
	arp_header_t next_header;
	logic        decide_q;  // Outputs loaded last cycle

	// Three outcomes of a finished frame
	always_comb begin
		next_type   = KIND_UNSUPPORTED;
		next_header = arp_header;        // Foreign destination keeps the old header
		if (ip_hit) begin
			if (oper_kind == KIND_UNSUPPORTED) begin
				next_header = '0;            // Ours but not a request
			end else begin
				next_type   = oper_kind;
				next_header = frame_header;
			end
		end
	end

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			arp_type   <= KIND_UNSUPPORTED;
			arp_header <= '0;
			decide_q   <= 1'b0;
			arp_done   <= 1'b0;
		end else begin
			decide_q <= decide;
			arp_done <= decide_q;  // One cycle after the load
			if (decide) begin
				arp_type   <= next_type;
				arp_header <= next_header;
			end
		end
	end

endmodule

//--- verilog/arp_target_match.sv
`timescale 1ns/100ps

module arp_target_match #(
	parameter arp_frame_pkg::ip_addr_t LOCAL_IP = 32'hC0A8_0001
) (
	input  logic                      CLK,
	input  logic                      RST,
	input  arp_frame_pkg::byte_t      in_data,
	input  arp_frame_pkg::byte_idx_t  byte_idx,
	input  logic                      byte_take,
	output logic                      ip_hit,
	output arp_decode_pkg::arp_kind_t oper_kind
);
	import arp_frame_pkg::*;
	import arp_decode_pkg::*;

	logic       ip_miss;      // Any destination IP byte differed
	logic       in_ip_field;
	logic [1:0] ip_pos;       // Byte within the destination IP
	byte_t      local_byte;
	byte_t      oper_hi;
	word16_t    oper;

	assign in_ip_field = (byte_idx >= OFS_DST_IP) &&
		(byte_idx < OFS_DST_IP + $bits(ip_addr_t) / 8);
	assign ip_pos      = 2'(byte_idx - OFS_DST_IP);
	assign local_byte  = LOCAL_IP[8 * (3 - ip_pos) +: 8];  // MSB first on the wire

	// Full opcode exists only while byte 7 is on in_data
	assign oper   = {oper_hi, in_data};
	assign ip_hit = ~ip_miss;

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			ip_miss   <= 1'b1;
			oper_kind <= KIND_UNSUPPORTED;
		end else if (byte_take) begin
			if (byte_idx == '0) begin
				ip_miss   <= 1'b0;          // New frame
				oper_kind <= KIND_UNSUPPORTED;
			end

			if (in_ip_field && in_data != local_byte)
				ip_miss <= 1'b1;

			if (byte_idx == OFS_OPER + 1) begin
				case (oper)
					OPER_ARP_REQUEST:  oper_kind <= KIND_ARP;
					OPER_RARP_REQUEST: oper_kind <= KIND_RARP;
					default:           oper_kind <= KIND_UNSUPPORTED;
				endcase
			end
		end
	end

	// Opcode high byte, held until byte 7 arrives
	always_ff @(posedge CLK) begin
		if (byte_take && byte_idx == OFS_OPER)
			oper_hi <= in_data;
	end

endmodule
